//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_store_buffer -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only -Wall -f sim.f --top-module store_buffer

clean:
	rm -rf obj_dir

//--- cache_port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_consts.svh"

module cache_port_arbiter
    import sb_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // load side
    input  logic                fwd_valid,
    input  logic [`SB_XLEN-1:0] fwd_data,
    input  logic                rd_need,
    input  mem_req_t            rd_req,

    // store side
    input  logic                head_ready,
    input  sb_entry_t           head,

    // cache response
    input  logic                ufp_resp,
    input  logic [`SB_XLEN-1:0] ufp_rdata,

    output logic                rd_issue,
    output logic                head_issue,
    output logic                head_done,
    output cache_req_t          ufp_req,
    output logic                load_resp,
    output logic [`SB_XLEN-1:0] load_data
);

    // one transaction in flight
    logic busy;

    // kind of the outstanding transaction
    logic rd_out;

    // response for the outstanding read
    logic rd_resp;

    // load wins over drain when the port is free
    assign rd_issue   = !busy && rd_need;
    assign head_issue = !busy && !rd_need && head_ready;

    // request strobe, one cycle wide
    always_comb begin
        ufp_req = '0;
        if (rd_issue) begin
            ufp_req.addr  = rd_req.addr;
            ufp_req.rmask = rd_req.mask;
        end else if (head_issue) begin
            ufp_req.addr  = head.addr;
            ufp_req.wmask = head.mask;
            ufp_req.wdata = head.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            rd_out <= 1'b0;
        end else if (rd_issue || head_issue) begin
            busy   <= 1'b1;
            rd_out <= rd_issue;
        end else if (ufp_resp) begin
            // port free again next cycle
            busy   <= 1'b0;
            rd_out <= 1'b0;
        end
    end

    // split the response by kind
    assign rd_resp   = ufp_resp && busy && rd_out;
    assign head_done = ufp_resp && busy && !rd_out;

    // a hit never makes a read, so at most one source per cycle
    assign load_resp = fwd_valid || rd_resp;

    always_comb begin
        if (fwd_valid) begin
            load_data = fwd_data;
        end else if (rd_resp) begin
            load_data = ufp_rdata;
        end else begin
            load_data = '0;
        end
    end

endmodule

`default_nettype wire

//--- load_forward.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_consts.svh"

module load_forward
    import sb_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // load from the memory stage
    input  mem_req_t            load_req,

    // registered queue contents
    input  sb_entries_t         entries,

    // read accepted by the arbiter
    input  logic                rd_issue,

    output logic                fwd_valid,
    output logic [`SB_XLEN-1:0] fwd_data,
    output logic                rd_need,
    output mem_req_t            rd_req
);

    // held load
    mem_req_t             pend;
    logic                 pend_valid;

    // first check already missed, stays a cache read
    logic                 missed;

    // search result
    logic                 hit;
    logic [`SB_IDX_W-1:0] hit_idx;

    // priority scan from the youngest slot down
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = `SB_DEPTH-1; i >= 0; i--) begin
            if (!hit && entries[i].valid &&
                (entries[i].addr == pend.addr) &&
                (entries[i].mask == pend.mask)) begin
                hit     = 1'b1;
                hit_idx = `SB_IDX_W'(i);
            end
        end
    end

    // forward only on the first check
    //   a later store is younger than this load
    assign fwd_valid = pend_valid && !missed && hit;
    assign fwd_data  = entries[hit_idx].data;

    // miss now or earlier
    assign rd_need = pend_valid && (missed || !hit);
    assign rd_req  = pend;

    // load payload
    always_ff @(posedge clk) begin
        if (load_req.mask != '0) begin
            pend <= load_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
            missed     <= 1'b0;
        end else if (load_req.mask != '0) begin
            // new load may come in the cycle of the previous load_resp
            pend_valid <= 1'b1;
            missed     <= 1'b0;
        end else if (fwd_valid || rd_issue) begin
            pend_valid <= 1'b0;
            missed     <= 1'b0;
        end else if (rd_need) begin
            // port busy, keep waiting as a read
            missed <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sb_consts.svh
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// data and address width of the rv32i memory stage
`define SB_XLEN 32

// number of store queue entries
`define SB_DEPTH 8

// index width into the queue, log2 of depth
`define SB_IDX_W 3

// byte mask width follows from the data width
//   one strobe bit per byte lane

`endif

//--- sb_pkg.sv
`default_nettype none

`include "sb_consts.svh"

package sb_pkg;

    // one store queue slot
    typedef struct packed {
        logic                    valid;
        // issued to the cache, waiting for ufp_resp
        logic                    sent;
        logic [`SB_XLEN-1:0]     addr;
        logic [`SB_XLEN/8-1:0]   mask;
        logic [`SB_XLEN-1:0]     data;
    } sb_entry_t;

    // pipeline request, load or store
    typedef struct packed {
        logic [`SB_XLEN-1:0]     addr;
        // zero mask means no request this cycle
        logic [`SB_XLEN/8-1:0]   mask;
        // don't care for loads
        logic [`SB_XLEN-1:0]     data;
    } mem_req_t;

    // request word toward the data cache
    typedef struct packed {
        logic [`SB_XLEN-1:0]     addr;
        logic [`SB_XLEN/8-1:0]   rmask;
        // never nonzero together with rmask
        logic [`SB_XLEN/8-1:0]   wmask;
        logic [`SB_XLEN-1:0]     wdata;
    } cache_req_t;

    // whole queue, index 0 is the oldest store
    typedef sb_entry_t [`SB_DEPTH-1:0] sb_entries_t;

endpackage

`default_nettype wire

//--- sim.f
+incdir+.
sb_pkg.sv
store_queue.sv
load_forward.sv
cache_port_arbiter.sv
store_buffer.sv
tb_clk_gen.sv
tb_store_buffer.sv

//--- store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_consts.svh"

module store_buffer
    import sb_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // memory stage requests
    input  mem_req_t            store_req,
    input  mem_req_t            load_req,

    // cache response
    input  logic                ufp_resp,
    input  logic [`SB_XLEN-1:0] ufp_rdata,

    // back to the memory stage
    output logic                store_resp,
    output logic                full,
    output logic                load_resp,
    output logic [`SB_XLEN-1:0] load_data,

    // toward the cache
    output cache_req_t          ufp_req
);

    // queue to load search
    sb_entries_t         entries;

    // queue to and from arbiter
    sb_entry_t           head;
    logic                head_ready;
    logic                head_issue;
    logic                head_done;

    // load search to and from arbiter
    logic                fwd_valid;
    logic [`SB_XLEN-1:0] fwd_data;
    logic                rd_need;
    mem_req_t            rd_req;
    logic                rd_issue;

    store_queue i_store_queue (
        .clk        (clk),
        .rst        (rst),
        .store_req  (store_req),
        .head_issue (head_issue),
        .head_done  (head_done),
        .store_resp (store_resp),
        .full       (full),
        .entries    (entries),
        .head       (head),
        .head_ready (head_ready)
    );

    load_forward i_load_forward (
        .clk       (clk),
        .rst       (rst),
        .load_req  (load_req),
        .entries   (entries),
        .rd_issue  (rd_issue),
        .fwd_valid (fwd_valid),
        .fwd_data  (fwd_data),
        .rd_need   (rd_need),
        .rd_req    (rd_req)
    );

    cache_port_arbiter i_cache_port_arbiter (
        .clk        (clk),
        .rst        (rst),
        .fwd_valid  (fwd_valid),
        .fwd_data   (fwd_data),
        .rd_need    (rd_need),
        .rd_req     (rd_req),
        .head_ready (head_ready),
        .head       (head),
        .ufp_resp   (ufp_resp),
        .ufp_rdata  (ufp_rdata),
        .rd_issue   (rd_issue),
        .head_issue (head_issue),
        .head_done  (head_done),
        .ufp_req    (ufp_req),
        .load_resp  (load_resp),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

//--- store_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "sb_consts.svh"

module store_queue
    import sb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // store from the memory stage
    input  mem_req_t    store_req,

    // drain control from the arbiter
    input  logic        head_issue,
    input  logic        head_done,

    output logic        store_resp,
    output logic        full,
    output sb_entries_t entries,
    output sb_entry_t   head,
    output logic        head_ready
);

    // registered queue and its next state
    sb_entries_t          q;
    sb_entries_t          q_next;

    // first free slot, counted after a shift
    logic [`SB_IDX_W-1:0] ins_idx;
    logic                 ins_found;

    always_comb begin
        q_next    = q;
        ins_idx   = '0;
        ins_found = 1'b0;

        // head handed to the cache this cycle
        if (head_issue) begin
            q_next[0].sent = 1'b1;
        end

        // head write answered, shift everything down one place
        if (head_done) begin
            for (int i = 0; i < `SB_DEPTH-1; i++) begin
                q_next[i] = q_next[i+1];
            end
            q_next[`SB_DEPTH-1] = '0;
        end

        // lowest invalid slot keeps program order
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (!ins_found && !q_next[i].valid) begin
                ins_found = 1'b1;
                ins_idx   = `SB_IDX_W'(i);
            end
        end

        // caller never stores while full, so a slot is there
        if ((store_req.mask != '0) && ins_found) begin
            q_next[ins_idx].valid = 1'b1;
            q_next[ins_idx].sent  = 1'b0;
            q_next[ins_idx].addr  = store_req.addr;
            q_next[ins_idx].mask  = store_req.mask;
            q_next[ins_idx].data  = store_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // only the flags, payload is don't care while invalid
            for (int i = 0; i < `SB_DEPTH; i++) begin
                q[i].valid <= 1'b0;
                q[i].sent  <= 1'b0;
            end
        end else begin
            q <= q_next;
        end
    end

    // store answered one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            store_resp <= 1'b0;
        end else begin
            store_resp <= (store_req.mask != '0);
        end
    end

    // full when every slot holds a store
    always_comb begin
        full = 1'b1;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            full = full & q[i].valid;
        end
    end

    // registered view for the load search
    assign entries = q;

    // oldest store goes out first
    assign head = q[0];

    // head still waiting for the port
    assign head_ready = q[0].valid && !q[0].sent;

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb_store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_store_buffer
    import sb_pkg::*;
();

    localparam int N_RAND  = 400;
    localparam int N_OPS   = N_RAND + 20;
    localparam int MAX_CYC = 40 * N_OPS + 200;

    // expected state of the one load in flight
    typedef struct packed {
        logic       pend;
        logic       hit;
        // cache read seen for it
        logic       sent;
        logic [7:0] age;
        // data field holds the predicted load value
        mem_req_t   req;
    } load_exp_t;

    logic        clk;
    logic        rst;
    mem_req_t    store_req;
    mem_req_t    load_req;
    logic        ufp_resp;
    logic [31:0] ufp_rdata;
    logic        store_resp;
    logic        full;
    logic        load_resp;
    logic [31:0] load_data;
    cache_req_t  ufp_req;

    integer      seed;
    int          cyc;
    int          rst_cnt;
    int          phase;
    int          op_cnt;
    int          hold;
    logic        done;

    // reference queue of stores accepted and not yet answered
    mem_req_t    sq[$];
    int          wr_ptr;
    logic [31:0] rmem[16];

    // cache model
    logic [31:0] cmem[16];
    logic        busy;
    logic        c_rd;
    logic [3:0]  c_idx;
    logic [3:0]  c_mask;
    int          c_cnt;
    logic        stall;

    load_exp_t   ld;

    // registered views that the assertions sample
    load_exp_t   ld_q;
    mem_req_t    exp_w;
    logic        exp_sresp;
    logic        exp_full;
    logic        port_busy;

    tb_clk_gen i_clk_gen (.clk(clk));

    store_buffer i_dut (
        .clk        (clk),
        .rst        (rst),
        .store_req  (store_req),
        .load_req   (load_req),
        .ufp_resp   (ufp_resp),
        .ufp_rdata  (ufp_rdata),
        .store_resp (store_resp),
        .full       (full),
        .load_resp  (load_resp),
        .load_data  (load_data),
        .ufp_req    (ufp_req)
    );

    function automatic logic [31:0] lanes(input logic [3:0] m);
        logic [31:0] v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = {8{m[b]}};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                          input logic [3:0] m);
        return (old & ~lanes(m)) | (d & lanes(m));
    endfunction

    task automatic report_error(input string name, input logic [67:0] exp_v,
                                input logic [67:0] act_v);
        $display("[ERROR] %s expected %0h actual %0h", name, exp_v, act_v);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    // random mask that is the full word half the time
    function automatic logic [3:0] pick_mask();
        logic [31:0] r;
        r = $random(seed);
        if (r[4]) begin
            return 4'hf;
        end
        return (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
    endfunction

    task automatic issue_store(input logic [3:0] idx);
        logic [3:0] m;
        m = pick_mask();
        // unused lanes zero so forward and cache paths agree
        store_req <= '{32'h2000 + {26'b0, idx, 2'b00}, m, $random(seed) & lanes(m)};
        op_cnt = op_cnt + 1;
    endtask

    task automatic issue_load(input logic [3:0] idx);
        logic [31:0] a;
        logic [3:0]  m;
        logic [31:0] d;
        logic        hit;
        a   = 32'h2000 + {26'b0, idx, 2'b00};
        hit = 1'b0;
        m   = 4'h0;
        d   = 32'h0;
        // youngest queued store to this word sets mask and data
        for (int i = sq.size() - 1; i >= 0; i--) begin
            if (!hit && sq[i].addr == a) begin
                hit = 1'b1;
                m   = sq[i].mask;
                d   = sq[i].data;
            end
        end
        if (!hit) begin
            m = pick_mask();
            d = rmem[idx] & lanes(m);
        end
        ld = '{1'b1, hit, 1'b0, 8'd0, '{a, m, d}};
        load_req <= '{a, m, 32'h0};
        op_cnt = op_cnt + 1;
    endtask

    initial begin
        seed      = 32'h580a_65e8;
        rst       = 1'b1;
        store_req = '0;
        load_req  = '0;
        ufp_resp  = 1'b0;
        ufp_rdata = '0;
        done      = 1'b0;
        busy      = 1'b0;
        c_rd      = 1'b0;
        stall     = 1'b0;
        ld        = '0;
        for (int i = 0; i < 16; i++) begin
            // fill depends on every address bit
            cmem[i] = (32'h2000 + 32'(i * 4)) * 32'h0001_0003 ^ 32'h5a5a_c3c3;
            rmem[i] = cmem[i];
        end
        wait (done);
        $display(">>> PASS");
        $finish;
    end

    always @(posedge clk) begin
        logic [31:0] r;
        logic [3:0]  idx;
        store_req <= '0;
        load_req  <= '0;
        ufp_resp  <= 1'b0;
        exp_sresp <= (store_req.mask != 4'h0);
        if (rst_cnt < 5) begin
            rst_cnt = rst_cnt + 1;
            if (rst_cnt == 5) begin
                rst <= 1'b0;
            end
        end else begin
            // store sampled by the DUT at this edge
            if (store_req.mask != 4'h0) begin
                sq.push_back(store_req);
            end
            // answered write leaves the queue at this edge
            if (ufp_resp) begin
                busy = 1'b0;
                if (!c_rd) begin
                    void'(sq.pop_front());
                    wr_ptr = wr_ptr - 1;
                end
            end
            if (load_resp) begin
                ld.pend = 1'b0;
            end
            if (ld.pend) begin
                ld.age = ld.age + 8'd1;
            end
            // cache side requests where writes land at once
            if (ufp_req.wmask != 4'h0) begin
                cmem[ufp_req.addr[5:2]] = merge(cmem[ufp_req.addr[5:2]], ufp_req.wdata,
                                                ufp_req.wmask);
                if (wr_ptr < sq.size()) begin
                    rmem[sq[wr_ptr].addr[5:2]] = merge(rmem[sq[wr_ptr].addr[5:2]],
                                                       sq[wr_ptr].data, sq[wr_ptr].mask);
                    wr_ptr = wr_ptr + 1;
                end
            end
            if (ufp_req.rmask != 4'h0) begin
                ld.sent = 1'b1;
            end
            if (ufp_req.wmask != 4'h0 || ufp_req.rmask != 4'h0) begin
                r      = $random(seed);
                busy   = 1'b1;
                c_rd   = (ufp_req.rmask != 4'h0);
                c_idx  = ufp_req.addr[5:2];
                c_mask = ufp_req.rmask;
                c_cnt  = int'(r[1:0]) + 1;
            end
            // response after 1 to 4 cycles unless stalled
            if (c_cnt > 0 && !stall) begin
                c_cnt = c_cnt - 1;
                if (c_cnt == 0) begin
                    ufp_resp  <= 1'b1;
                    ufp_rdata <= c_rd ? (cmem[c_idx] & lanes(c_mask)) : 32'h0;
                end
            end
            r   = $random(seed);
            idx = r[7:4];
            case (phase)
                0: begin
                    // mixed traffic where stores never hit the pending load word
                    if (r[1:0] < 2'd2 && sq.size() < 8 &&
                        !(ld.pend && ld.req.addr[5:2] == idx)) begin
                        issue_store(idx);
                    end else if (r[1:0] == 2'd2 && !ld.pend) begin
                        issue_load(idx);
                    end
                    if (op_cnt >= N_RAND) begin
                        phase = 1;
                    end
                end
                1: if (sq.size() == 0 && !ld.pend && !busy) begin
                    stall = 1'b1;
                    phase = 2;
                end
                2: if (sq.size() < 8) begin
                    issue_store(idx);
                end else begin
                    hold  = 0;
                    phase = 3;
                end
                3: begin
                    hold = hold + 1;
                    if (hold == 10) begin
                        stall = 1'b0;
                        phase = 4;
                    end
                end
                4: if (sq.size() < 8) begin
                    issue_store(idx);
                    phase = 5;
                end
                default: if (sq.size() == 0 && !ld.pend && !busy) begin
                    done = 1'b1;
                end
            endcase
        end
        exp_full  <= (sq.size() == 8);
        exp_w     <= (wr_ptr < sq.size()) ? sq[wr_ptr] : '0;
        port_busy <= busy;
        ld_q      <= ld;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("run did not finish within %0d cycles", MAX_CYC);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    a_store_resp: assert property (@(posedge clk) disable iff (rst) store_resp == exp_sresp)
        else report_error("store_resp", 68'(exp_sresp), 68'(store_resp));

    a_full: assert property (@(posedge clk) disable iff (rst) full == exp_full)
        else report_error("full", 68'(exp_full), 68'(full));

    // one transaction at a time and never a read with a write
    a_port: assert property (@(posedge clk) disable iff (rst)
        (ufp_req.rmask != 4'h0 || ufp_req.wmask != 4'h0) |->
        (!port_busy && (ufp_req.rmask == 4'h0 || ufp_req.wmask == 4'h0)))
        else report_error("port_busy", 68'(0), 68'({ufp_req.rmask, ufp_req.wmask}));

    a_write: assert property (@(posedge clk) disable iff (rst)
        ufp_req.wmask != 4'h0 |->
        {ufp_req.addr, ufp_req.wmask, ufp_req.wdata} == exp_w)
        else report_error("write_order", exp_w,
                          {ufp_req.addr, ufp_req.wmask, ufp_req.wdata});

    a_read: assert property (@(posedge clk) disable iff (rst)
        ufp_req.rmask != 4'h0 |-> (ld_q.pend && !ld_q.hit && !ld_q.sent &&
        ufp_req.addr == ld_q.req.addr && ufp_req.rmask == ld_q.req.mask))
        else report_error("read_req", 68'({ld_q.req.addr, ld_q.req.mask}),
                          68'({ufp_req.addr, ufp_req.rmask}));

    // read goes before a waiting store
    a_read_first: assert property (@(posedge clk) disable iff (rst)
        ufp_req.wmask != 4'h0 |->
        !(ld_q.pend && !ld_q.hit && !ld_q.sent && ld_q.age >= 8'd1))
        else report_error("read_priority", 68'(0), 68'(ufp_req.wmask));

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        load_resp |-> (ld_q.pend && load_data == ld_q.req.data &&
        (ld_q.hit || (ufp_resp && ld_q.sent))))
        else report_error("load_data", 68'(ld_q.req.data), 68'(load_data));

    a_hit_time: assert property (@(posedge clk) disable iff (rst)
        (ld_q.pend && ld_q.hit && ld_q.age == 8'd1) |-> load_resp)
        else report_error("hit_latency", 68'(1), 68'(load_resp));

endmodule

`default_nettype wire
